/* verilog/mvsPkg.sv */
`default_nettype none

package mvsPkg;

	// Decoded CPU regions
	typedef enum logic [1:0]
	{
		sysRam,
		ioRegs,
		palRam,
		unmapped
	} regionE;

	// Longword adapter sequence
	typedef enum logic [1:0]
	{
		idle,
		firstWord,
		secondWord,
		done
	} adapterStateE;

	// Work RAM at 0xC00000, mirrored over the whole 1MB window
	localparam logic [23:0] SYS_RAM_BASE = 24'hC00000;
	localparam int SYS_RAM_WORDS = 64;
	localparam int SYS_AW = $clog2(SYS_RAM_WORDS);

	// Vector area redirected to system RAM while the swap is on
	localparam logic [23:0] VEC_LIMIT = 24'h000080;

	// I/O block, 0x300000 to 0x3FFFFF
	localparam logic [23:0] IO_BASE = 24'h300000;
	// Byte offsets inside the I/O window
	localparam logic [19:0] P1_OFS = 20'h00000;
	localparam logic [19:0] P2_OFS = 20'h40000;
	localparam logic [19:0] OUT_OFS = 20'h80000;
	localparam logic [19:0] SWAP_SYS_OFS = 20'hA0012;
	localparam logic [19:0] SWAP_CART_OFS = 20'hA0002;

	// Palette RAM, one bank only
	localparam logic [23:0] PAL_BASE = 24'h400000;
	localparam int PAL_WORDS = 256;
	localparam int PAL_AW = $clog2(PAL_WORDS);

	// Open bus value
	localparam logic [15:0] UNMAPPED_DATA = 16'hFFFF;

endpackage

`default_nettype wire

/* verilog/wordBusIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface wordBusIf;

	// Single-cycle request strobe
	logic req;
	logic we;
	// Word address, byte address bits 23:1
	logic [22:0] addr;
	// Upper and lower byte strobes
	logic [1:0] byteEn;
	logic [15:0] wdata;
	// Valid while ack is high
	logic [15:0] rdata;
	logic ack;

	modport master
	(
		output req, we, addr, byteEn, wdata,
		input rdata, ack
	);

	modport slave
	(
		input req, we, addr, byteEn, wdata,
		output rdata, ack
	);

endinterface

`default_nettype wire

/* verilog/longAdapter.sv */
`timescale 1ns/1ps
`default_nettype none

module longAdapter
	import mvsPkg::*;
(
	input wire clk24M,
	input wire rstN,
	input wire req,
	input wire we,
	input wire isLong,
	input wire [1:0] byteEn,
	input wire [23:0] addr,
	input wire [31:0] wdata,
	output logic [31:0] rdata,
	output logic ack,
	wordBusIf.master bus
);

	adapterStateE state;
	logic busReq;

	// Host access captured at request time
	logic weQ;
	logic longQ;
	logic [1:0] byteEnQ;
	logic [22:0] addrQ;
	logic [31:0] wdataQ;

	// Sequencer, word cycles one at a time
	always_ff @(posedge clk24M or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			busReq <= 1'b0;
		end
		else
		begin
			busReq <= 1'b0;
			case (state)
				idle:
				begin
					if (req)
					begin
						busReq <= 1'b1;
						state <= firstWord;
					end
				end
				firstWord:
				begin
					if (bus.ack)
					begin
						// Longword needs the second half
						busReq <= longQ;
						state <= longQ ? secondWord : done;
					end
				end
				secondWord:
				begin
					if (bus.ack)
						state <= done;
				end
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk24M)
	begin
		if ((state == idle) && req)
		begin
			weQ <= we;
			longQ <= isLong;
			byteEnQ <= byteEn;
			addrQ <= addr[23:1];
			wdataQ <= wdata;
		end
		// High word comes first, from the lower address
		if (bus.ack)
		begin
			if (state == firstWord)
				rdata <= longQ ? {bus.rdata, 16'h0000} : {16'h0000, bus.rdata};
			else
				rdata[15:0] <= bus.rdata;
		end
	end

	assign bus.req = busReq;
	assign bus.we = weQ;
	// Second word sits at hostAddr+2
	assign bus.addr = (state == secondWord) ? addrQ + 23'd1 : addrQ;
	assign bus.byteEn = longQ ? 2'b11 : byteEnQ;
	assign bus.wdata = (longQ && (state != secondWord)) ? wdataQ[31:16] : wdataQ[15:0];

	// One cycle after the last word ack
	assign ack = (state == done);

	// Host must wait for its ack
	assert property (@(posedge clk24M) disable iff (!rstN) req |-> (state == idle));

endmodule

`default_nettype wire

/* verilog/addrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module addrDecode
	import mvsPkg::*;
(
	input wire clk24M,
	input wire rstN,
	input wire swapSys,
	wordBusIf.slave cpu,
	wordBusIf.master sysBus,
	wordBusIf.master ioBus,
	wordBusIf.master palBus
);

	logic [23:0] byteAddr;
	logic [23:0] mapAddr;
	regionE region;
	// Region of the cycle in flight
	regionE regionQ;
	// Ack for system RAM and open bus
	logic localAck;

	always_comb
	begin
		byteAddr = {cpu.addr, 1'b0};
		// Vector swap, low vectors come from work RAM
		if (swapSys && (byteAddr < VEC_LIMIT))
			mapAddr = SYS_RAM_BASE | byteAddr;
		else
			mapAddr = byteAddr;
		case (mapAddr[23:20])
			SYS_RAM_BASE[23:20]: region = sysRam;
			IO_BASE[23:20]: region = ioRegs;
			PAL_BASE[23:20]: region = palRam;
			default: region = unmapped;
		endcase
	end

	// Same cycle forward, only the selected peer sees req
	assign sysBus.req = cpu.req && (region == sysRam);
	assign ioBus.req = cpu.req && (region == ioRegs);
	assign palBus.req = cpu.req && (region == palRam);

	assign sysBus.we = cpu.we;
	assign ioBus.we = cpu.we;
	assign palBus.we = cpu.we;
	assign sysBus.addr = mapAddr[23:1];
	assign ioBus.addr = mapAddr[23:1];
	assign palBus.addr = mapAddr[23:1];
	assign sysBus.byteEn = cpu.byteEn;
	assign ioBus.byteEn = cpu.byteEn;
	assign palBus.byteEn = cpu.byteEn;
	assign sysBus.wdata = cpu.wdata;
	assign ioBus.wdata = cpu.wdata;
	assign palBus.wdata = cpu.wdata;

	always_ff @(posedge clk24M or negedge rstN)
	begin
		if (!rstN)
		begin
			localAck <= 1'b0;
			regionQ <= unmapped;
		end
		else
		begin
			localAck <= cpu.req && ((region == sysRam) || (region == unmapped));
			if (cpu.req)
				regionQ <= region;
		end
	end

	// Return path, unmapped writes just vanish
	always_comb
	begin
		case (regionQ)
			sysRam:
			begin
				cpu.ack = localAck;
				cpu.rdata = sysBus.rdata;
			end
			ioRegs:
			begin
				cpu.ack = ioBus.ack;
				cpu.rdata = ioBus.rdata;
			end
			palRam:
			begin
				cpu.ack = palBus.ack;
				cpu.rdata = palBus.rdata;
			end
			default:
			begin
				cpu.ack = localAck;
				cpu.rdata = UNMAPPED_DATA;
			end
		endcase
	end

	assert property (@(posedge clk24M) disable iff (!rstN)
		$onehot0({sysBus.req, ioBus.req, palBus.req}));

	// Palette wait included, no peer takes longer
	assert property (@(posedge clk24M) disable iff (!rstN)
		cpu.req |-> ##[1:2] cpu.ack);

endmodule

`default_nettype wire

/* verilog/palArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module palArbiter
	import mvsPkg::*;
(
	input wire clk24M,
	input wire rstN,
	input wire vidReq,
	input wire [7:0] vidIndex,
	input wire [15:0] ramRdata,
	output logic [15:0] vidData,
	output logic ramWe,
	output logic [PAL_AW-1:0] ramAddr,
	output logic [1:0] ramByteEn,
	output logic [15:0] ramWdata,
	wordBusIf.slave cpu
);

	// CPU request parked behind a video slot
	logic pending;
	logic cpuWant;
	logic cpuGrant;
	logic vidGrant;
	logic ackQ;

	assign cpuWant = cpu.req || pending;
	// Video always takes its slot
	assign vidGrant = vidReq;
	assign cpuGrant = cpuWant && !vidGrant;

	always_ff @(posedge clk24M or negedge rstN)
	begin
		if (!rstN)
		begin
			pending <= 1'b0;
			ackQ <= 1'b0;
		end
		else
		begin
			pending <= cpuWant && vidGrant;
			// RAM output is valid the cycle after the grant
			ackQ <= cpuGrant;
		end
	end

	// CPU fields stay put until its ack
	assign ramAddr = vidGrant ? vidIndex : cpu.addr[PAL_AW-1:0];
	assign ramWe = cpuGrant && cpu.we;
	assign ramByteEn = cpu.byteEn;
	assign ramWdata = cpu.wdata;

	assign vidData = ramRdata;
	assign cpu.rdata = ramRdata;
	assign cpu.ack = ackQ;

	assert property (@(posedge clk24M) disable iff (!rstN) !(vidGrant && cpuGrant));

	// Back-to-back video slots would starve the CPU
	assert property (@(posedge clk24M) disable iff (!rstN) vidReq |=> !vidReq);

endmodule

`default_nettype wire

/* verilog/wordRam.sv */
`timescale 1ns/1ps
`default_nettype none

module wordRam #(
	parameter int AW = 8
)
(
	input wire clk24M,
	input wire we,
	input wire [AW-1:0] addr,
	input wire [1:0] byteEn,
	input wire [15:0] wdata,
	output logic [15:0] rdata
);

	logic [15:0] mem [2**AW];

	always_ff @(posedge clk24M)
	begin
		if (we)
		begin
			// Upper byte lane
			if (byteEn[1])
				mem[addr][15:8] <= wdata[15:8];
			if (byteEn[0])
				mem[addr][7:0] <= wdata[7:0];
		end
		// Read returns old data on a write cycle
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

/* verilog/ioRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module ioRegs
	import mvsPkg::*;
(
	input wire clk24M,
	input wire rstN,
	input wire [9:0] p1In,
	input wire [9:0] p2In,
	input wire [7:0] dipSw,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic swapSys,
	wordBusIf.slave bus
);

	// Byte offset inside the 1MB I/O window
	logic [19:0] ofs;
	logic ackQ;
	logic [15:0] rdataQ;

	assign ofs = {bus.addr[18:0], 1'b0};

	always_ff @(posedge clk24M or negedge rstN)
	begin
		if (!rstN)
		begin
			ackQ <= 1'b0;
			p1Out <= 3'b000;
			p2Out <= 3'b000;
			// Boots on the system vectors
			swapSys <= 1'b1;
		end
		else
		begin
			ackQ <= bus.req;
			if (bus.req && bus.we)
			begin
				case (ofs)
					OUT_OFS:
					begin
						// Output latch sits on the low byte
						if (bus.byteEn[0])
						begin
							p1Out <= bus.wdata[2:0];
							p2Out <= bus.wdata[5:3];
						end
					end
					SWAP_SYS_OFS:
						swapSys <= 1'b1;
					SWAP_CART_OFS:
						swapSys <= 1'b0;
					default:
						;
				endcase
			end
		end
	end

	// Read mux, everything else reads zero
	always_ff @(posedge clk24M)
	begin
		if (bus.req)
		begin
			case (ofs)
				P1_OFS: rdataQ <= {dipSw, p1In[7:0]};
				P2_OFS: rdataQ <= {6'b000000, p2In};
				default: rdataQ <= 16'h0000;
			endcase
		end
	end

	assign bus.ack = ackQ;
	assign bus.rdata = rdataQ;

endmodule

`default_nettype wire

/* verilog/videoScan.sv */
`timescale 1ns/1ps
`default_nettype none

module videoScan
(
	input wire clk24M,
	input wire rstN,
	input wire [15:0] vidData,
	output logic vidReq,
	output logic [7:0] vidIndex,
	output logic [4:0] red,
	output logic [4:0] green,
	output logic [4:0] blue,
	output logic [7:0] pixIndex
);

	// Pixel slot toggle, requests on even cycles
	logic phase;
	logic [7:0] index;
	// One stage behind the request
	logic reqD;
	logic [7:0] indexD;

	assign vidReq = !phase;
	assign vidIndex = index;

	always_ff @(posedge clk24M or negedge rstN)
	begin
		if (!rstN)
		begin
			phase <= 1'b0;
			index <= 8'd0;
			reqD <= 1'b0;
		end
		else
		begin
			phase <= !phase;
			// Wraps after 255
			if (vidReq)
				index <= index + 8'd1;
			reqD <= vidReq;
		end
	end

	always_ff @(posedge clk24M)
	begin
		if (vidReq)
			indexD <= index;
		// Palette word arrives now, bit 15 unused
		if (reqD)
		begin
			red <= vidData[14:10];
			green <= vidData[9:5];
			blue <= vidData[4:0];
			pixIndex <= indexD;
		end
	end

endmodule

`default_nettype wire

/* verilog/mvsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mvsCore
	import mvsPkg::*;
(
	input wire clk24M,
	input wire rstN,
	input wire hostReq,
	input wire hostWe,
	input wire hostLong,
	input wire [1:0] hostByteEn,
	input wire [23:0] hostAddr,
	input wire [31:0] hostWdata,
	output wire [31:0] hostRdata,
	output wire hostAck,
	input wire [9:0] p1In,
	input wire [9:0] p2In,
	input wire [7:0] dipSw,
	output wire [2:0] p1Out,
	output wire [2:0] p2Out,
	output wire [4:0] red,
	output wire [4:0] green,
	output wire [4:0] blue,
	output wire [7:0] pixIndex
);

	// CPU side word bus and one per peer
	wordBusIf cpuBus();
	wordBusIf sysBus();
	wordBusIf ioBus();
	wordBusIf palBus();

	logic swapSys;

	// Video fetch port
	logic vidReq;
	logic [7:0] vidIndex;
	logic [15:0] vidData;

	// Palette RAM pins
	logic palWe;
	logic [PAL_AW-1:0] palAddr;
	logic [1:0] palByteEn;
	logic [15:0] palWdata;
	logic [15:0] palRdata;

	longAdapter u_longAdapter
	(
		.clk24M(clk24M),
		.rstN(rstN),
		.req(hostReq),
		.we(hostWe),
		.isLong(hostLong),
		.byteEn(hostByteEn),
		.addr(hostAddr),
		.wdata(hostWdata),
		.rdata(hostRdata),
		.ack(hostAck),
		.bus(cpuBus.master)
	);

	addrDecode u_addrDecode
	(
		.clk24M(clk24M),
		.rstN(rstN),
		.swapSys(swapSys),
		.cpu(cpuBus.slave),
		.sysBus(sysBus.master),
		.ioBus(ioBus.master),
		.palBus(palBus.master)
	);

	// Work RAM ack is generated in the decoder
	wordRam #(.AW(SYS_AW)) u_sysRam
	(
		.clk24M(clk24M),
		.we(sysBus.req && sysBus.we),
		.addr(sysBus.addr[SYS_AW-1:0]),
		.byteEn(sysBus.byteEn),
		.wdata(sysBus.wdata),
		.rdata(sysBus.rdata)
	);

	ioRegs u_ioRegs
	(
		.clk24M(clk24M),
		.rstN(rstN),
		.p1In(p1In),
		.p2In(p2In),
		.dipSw(dipSw),
		.p1Out(p1Out),
		.p2Out(p2Out),
		.swapSys(swapSys),
		.bus(ioBus.slave)
	);

	palArbiter u_palArbiter
	(
		.clk24M(clk24M),
		.rstN(rstN),
		.vidReq(vidReq),
		.vidIndex(vidIndex),
		.ramRdata(palRdata),
		.vidData(vidData),
		.ramWe(palWe),
		.ramAddr(palAddr),
		.ramByteEn(palByteEn),
		.ramWdata(palWdata),
		.cpu(palBus.slave)
	);

	wordRam #(.AW(PAL_AW)) u_palRam
	(
		.clk24M(clk24M),
		.we(palWe),
		.addr(palAddr),
		.byteEn(palByteEn),
		.wdata(palWdata),
		.rdata(palRdata)
	);

	videoScan u_videoScan
	(
		.clk24M(clk24M),
		.rstN(rstN),
		.vidData(vidData),
		.vidReq(vidReq),
		.vidIndex(vidIndex),
		.red(red),
		.green(green),
		.blue(blue),
		.pixIndex(pixIndex)
	);

endmodule

`default_nettype wire

/* dv/tbMvsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMvsCore
	import mvsPkg::*;
();

	// Host access limit in clocks, covers the palette wait
	localparam int ACK_TIMEOUT = 20;
	// Enough clocks for two full video scans
	localparam int SCAN_CLOCKS = 4 * PAL_WORDS + 16;

	logic clk24M = 1'b0;
	logic rstN;
	logic hostReq;
	logic hostWe;
	logic hostLong;
	logic [1:0] hostByteEn;
	logic [23:0] hostAddr;
	logic [31:0] hostWdata;
	logic [31:0] hostRdata;
	logic hostAck;
	logic [9:0] p1In;
	logic [9:0] p2In;
	logic [7:0] dipSw;
	logic [2:0] p1Out;
	logic [2:0] p2Out;
	logic [4:0] red;
	logic [4:0] green;
	logic [4:0] blue;
	logic [7:0] pixIndex;

	// Reference copies of both RAMs
	logic [15:0] sysModel [SYS_RAM_WORDS];
	logic [15:0] palModel [PAL_WORDS];
	logic palValid [PAL_WORDS];
	// Entries seen on the RGB outputs
	logic palSeen [PAL_WORDS];
	logic [31:0] seed;

	mvsCore u_dut
	(
		.clk24M(clk24M),
		.rstN(rstN),
		.hostReq(hostReq),
		.hostWe(hostWe),
		.hostLong(hostLong),
		.hostByteEn(hostByteEn),
		.hostAddr(hostAddr),
		.hostWdata(hostWdata),
		.hostRdata(hostRdata),
		.hostAck(hostAck),
		.p1In(p1In),
		.p2In(p2In),
		.dipSw(dipSw),
		.p1Out(p1Out),
		.p2Out(p2Out),
		.red(red),
		.green(green),
		.blue(blue),
		.pixIndex(pixIndex)
	);

	// 10 ns clock
	always #5 clk24M = ~clk24M;

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
			abortRun($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	// Standard LCG step
	function automatic logic [31:0] nextRand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte lanes as the bus defines them
	function automatic logic [15:0] mergeBytes(input logic [15:0] old,
		input logic [15:0] data, input logic [1:0] be);
		logic [15:0] merged;
		merged = old;
		if (be[1])
			merged[15:8] = data[15:8];
		if (be[0])
			merged[7:0] = data[7:0];
		return merged;
	endfunction

	function automatic logic [23:0] sysAddr(input int idx);
		return SYS_RAM_BASE + 24'(idx * 2);
	endfunction

	function automatic logic [23:0] palAddr(input int idx);
		return PAL_BASE + 24'(idx * 2);
	endfunction

	// One host request, then wait for its ack
	task automatic hostAccess(input logic we, input logic isLong, input logic [1:0] be,
		input logic [23:0] addr, input logic [31:0] wdata, output logic [31:0] rdata);
		int waitCount;
		logic gotAck;
		@(negedge clk24M);
		hostReq = 1'b1;
		hostWe = we;
		hostLong = isLong;
		hostByteEn = be;
		hostAddr = addr;
		hostWdata = wdata;
		gotAck = 1'b0;
		waitCount = 0;
		while (!gotAck && (waitCount < ACK_TIMEOUT))
		begin
			@(negedge clk24M);
			// Request is a single clock pulse
			hostReq = 1'b0;
			gotAck = hostAck;
			waitCount++;
		end
		if (!gotAck)
			abortRun($sformatf("host access to %h got no ack within %0d clocks",
				addr, ACK_TIMEOUT));
		else
			rdata = hostRdata;
	endtask

	task automatic writeWord(input logic [23:0] addr, input logic [15:0] data,
		input logic [1:0] be);
		logic [31:0] discard;
		hostAccess(1'b1, 1'b0, be, addr, {16'h0000, data}, discard);
	endtask

	task automatic writeLong(input logic [23:0] addr, input logic [31:0] data);
		logic [31:0] discard;
		hostAccess(1'b1, 1'b1, 2'b11, addr, data, discard);
	endtask

	// Word reads come back in the low half
	task automatic expectWord(input logic [23:0] addr, input logic [15:0] exp);
		logic [31:0] got;
		hostAccess(1'b0, 1'b0, 2'b11, addr, 32'h0, got);
		checkValue($sformatf("hostRdata at %h", addr), got, {16'h0000, exp});
	endtask

	task automatic expectLong(input logic [23:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		hostAccess(1'b0, 1'b1, 2'b11, addr, 32'h0, got);
		checkValue($sformatf("hostRdata long at %h", addr), got, exp);
	endtask

	// Host ack is a single-cycle pulse
	assert property (@(posedge clk24M) disable iff (!rstN) hostAck |=> !hostAck)
	else
		abortRun("hostAck stayed high for more than one clock");

	initial
	begin : stimulus
		int idx;
		int n;
		logic [1:0] be;
		rstN = 1'b0;
		hostReq = 1'b0;
		hostWe = 1'b0;
		hostLong = 1'b0;
		hostByteEn = 2'b00;
		hostAddr = 24'h000000;
		hostWdata = 32'h00000000;
		p1In = 10'h000;
		p2In = 10'h000;
		dipSw = 8'h00;
		seed = 32'h6cbd;
		for (idx = 0; idx < PAL_WORDS; idx++)
		begin
			palValid[idx] = 1'b0;
			palSeen[idx] = 1'b0;
		end
		repeat (2) @(negedge clk24M);
		rstN = 1'b1;
		checkValue("p1Out", {29'b0, p1Out}, 32'h0);
		checkValue("p2Out", {29'b0, p2Out}, 32'h0);

		// Work RAM fill, one longword per word pair
		for (idx = 0; idx < SYS_RAM_WORDS; idx += 2)
		begin
			seed = nextRand(seed);
			writeLong(sysAddr(idx), seed);
			sysModel[idx] = seed[31:16];
			sysModel[idx + 1] = seed[15:0];
		end
		// Fixed byte lane cases on word 0x10
		writeWord(sysAddr(16), 16'h1234, 2'b11);
		writeWord(sysAddr(16), 16'hab00, 2'b10);
		writeWord(sysAddr(16), 16'h0078, 2'b01);
		sysModel[16] = 16'hab78;
		// Random lanes, zero enables included
		for (n = 0; n < 16; n++)
		begin
			seed = nextRand(seed);
			idx = int'(seed[21:16]);
			be = seed[23:22];
			writeWord(sysAddr(idx), seed[15:0], be);
			sysModel[idx] = mergeBytes(sysModel[idx], seed[15:0], be);
		end
		for (idx = 0; idx < SYS_RAM_WORDS; idx++)
			expectWord(sysAddr(idx), sysModel[idx]);
		// High word from the lower address
		for (idx = 0; idx < SYS_RAM_WORDS; idx += 8)
			expectLong(sysAddr(idx), {sysModel[idx], sysModel[idx + 1]});

		// Swap is on out of reset
		expectWord(24'h000010, sysModel[8]);
		writeWord(24'h000012, 16'h4e71, 2'b11);
		sysModel[9] = 16'h4e71;
		expectWord(sysAddr(9), 16'h4e71);
		writeWord(IO_BASE | {4'h0, SWAP_CART_OFS}, 16'h0000, 2'b11);
		// Low area is open bus now
		expectWord(24'h000010, UNMAPPED_DATA);
		writeWord(IO_BASE | {4'h0, SWAP_SYS_OFS}, 16'h0000, 2'b11);
		expectWord(24'h000010, sysModel[8]);

		// Player inputs, DIP switches and the output latch
		for (n = 0; n < 4; n++)
		begin
			seed = nextRand(seed);
			@(negedge clk24M);
			p1In = seed[9:0];
			p2In = seed[19:10];
			dipSw = seed[27:20];
			expectWord(IO_BASE | {4'h0, P1_OFS}, {dipSw, p1In[7:0]});
			expectWord(IO_BASE | {4'h0, P2_OFS}, {6'b000000, p2In});
			writeWord(IO_BASE | {4'h0, OUT_OFS}, seed[15:0], 2'b11);
			checkValue("p1Out", {29'b0, p1Out}, {29'b0, seed[2:0]});
			checkValue("p2Out", {29'b0, p2Out}, {29'b0, seed[5:3]});
		end

		// Palette writes race the scanner
		for (n = 0; n < 48; n++)
		begin
			seed = nextRand(seed);
			idx = int'(seed[23:16]);
			writeWord(palAddr(idx), seed[15:0], 2'b11);
			palModel[idx] = seed[15:0];
			palValid[idx] = 1'b1;
		end
		seed = nextRand(seed);
		writeLong(palAddr(254), seed);
		palModel[254] = seed[31:16];
		palModel[255] = seed[15:0];
		palValid[254] = 1'b1;
		palValid[255] = 1'b1;
		for (idx = 0; idx < PAL_WORDS; idx++)
		begin
			if (palValid[idx])
				expectWord(palAddr(idx), palModel[idx]);
		end
		expectLong(palAddr(254), {palModel[254], palModel[255]});

		// Drain video reads issued before the last write
		repeat (4) @(negedge clk24M);
		for (n = 0; n < SCAN_CLOCKS; n++)
		begin
			@(negedge clk24M);
			if (palValid[pixIndex])
			begin
				checkValue($sformatf("red at index %h", pixIndex), {27'b0, red},
					{27'b0, palModel[pixIndex][14:10]});
				checkValue($sformatf("green at index %h", pixIndex), {27'b0, green},
					{27'b0, palModel[pixIndex][9:5]});
				checkValue($sformatf("blue at index %h", pixIndex), {27'b0, blue},
					{27'b0, palModel[pixIndex][4:0]});
				palSeen[pixIndex] = 1'b1;
			end
		end
		for (idx = 0; idx < PAL_WORDS; idx++)
		begin
			assert (!palValid[idx] || palSeen[idx])
			else
				abortRun($sformatf("palette index %0d never showed up on pixIndex", idx));
		end

		// Open bus reads and dropped writes
		expectWord(24'h600000, UNMAPPED_DATA);
		expectLong(24'h600000, {UNMAPPED_DATA, UNMAPPED_DATA});
		seed = nextRand(seed);
		writeWord(24'h600000, seed[15:0], 2'b11);
		writeLong(24'h600010, seed);
		expectWord(24'h600000, UNMAPPED_DATA);
		for (idx = 0; idx < SYS_RAM_WORDS; idx++)
			expectWord(sysAddr(idx), sysModel[idx]);
		for (idx = 0; idx < PAL_WORDS; idx++)
		begin
			if (palValid[idx])
				expectWord(palAddr(idx), palModel[idx]);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
verilog/mvsPkg.sv
verilog/wordBusIf.sv
verilog/longAdapter.sv
verilog/addrDecode.sv
verilog/palArbiter.sv
verilog/wordRam.sv
verilog/ioRegs.sv
verilog/videoScan.sv
verilog/mvsCore.sv
dv/tbMvsCore.sv

/* Makefile */
TOP = tbMvsCore

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
